/* list.f */
hdl/divider_pkg.sv
hdl/divstage64.sv
hdl/div_operand_prep.sv
hdl/div_iter_core.sv
hdl/div_result_fmt.sv
hdl/int_divider.sv
test/int_divider_props.sv
test/int_divider_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the integer divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module int_divider_tb -f list.f \
    -Mdir "$BUILD_DIR" -o sim_int_divider
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_int_divider" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG_FILE"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

/* test/int_divider_tb.sv */
//****************************************
// testbench for the 64-bit integer divider
// random and corner-case requests checked
// against a reference model
//****************************************

`timescale 1ns/10ps

module int_divider_tb;

    import divider_pkg::*;

    localparam int clk_period = 20;
    localparam int n_random   = 24;
    // three random sets, twelve corner cases and four busy tests
    localparam int n_ops      = 3 * n_random + 12 + 4;
    localparam int latency    = 18;
    localparam int watchdog_cycles = n_ops * 25 + 100;

    logic            clk;
    logic            reset;
    logic            ena;
    logic            unsigned_op;
    logic            rem_op;
    logic            word_op;
    logic [xlen-1:0] a1;
    logic [xlen-1:0] a2;
    logic [xlen-1:0] res;
    logic            valid;
    logic            busy;

    logic [31:0]     lfsr;
    int              cycle;
    int              value_errors;
    int              proto_errors;
    int              issued;
    int              received;
    logic [xlen-1:0] exp_q[$];
    int              issue_q[$];

    int_divider dut_i (
        .clk         (clk),
        .reset       (reset),
        .ena         (ena),
        .unsigned_op (unsigned_op),
        .rem_op      (rem_op),
        .word_op     (word_op),
        .a1          (a1),
        .a2          (a2),
        .res         (res),
        .valid       (valid),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // edge counter for latency measurement
    initial begin
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle++;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // random magnitude of varying width so quotient sizes spread out
    function automatic logic [xlen-1:0] rand_operand();
        logic [1:0]      sel;
        logic [xlen-1:0] v;
        sel = 2'(take_bits(2));
        v   = take_bits(64);
        case (sel)
            2'd0:    v = v & 64'h0000_0000_0000_00ff;
            2'd1:    v = v & 64'h0000_0000_00ff_ffff;
            2'd2:    v = v & 64'h0000_ffff_ffff_ffff;
            default: v = v;
        endcase
        return v;
    endfunction

    // expected result from the RISC-V division rules
    function automatic logic [xlen-1:0] ref_result(input logic uns, input logic rem,
            input logic word, input logic [xlen-1:0] x, input logic [xlen-1:0] y);
        logic [xlen-1:0] n;
        logic [xlen-1:0] d;
        logic [xlen-1:0] most_neg;
        logic [xlen-1:0] an;
        logic [xlen-1:0] ad;
        logic [xlen-1:0] q;
        logic [xlen-1:0] r;
        logic [xlen-1:0] v;
        logic            sn;
        logic            sd;
        if (word) begin
            n        = uns ? {32'h0, x[31:0]} : {{32{x[31]}}, x[31:0]};
            d        = uns ? {32'h0, y[31:0]} : {{32{y[31]}}, y[31:0]};
            most_neg = {{33{1'b1}}, 31'h0};
        end else begin
            n        = x;
            d        = y;
            most_neg = {1'b1, 63'h0};
        end
        sn = !uns && n[63];
        sd = !uns && d[63];
        if (d == '0) begin
            q = '1;
            r = n;
        end else if (!uns && n == most_neg && d == '1) begin
            q = n;
            r = '0;
        end else begin
            an = sn ? -n : n;
            ad = sd ? -d : d;
            q  = an / ad;
            r  = an % ad;
            // truncation toward zero, remainder follows the dividend
            if (sn != sd) q = -q;
            if (sn) r = -r;
        end
        v = rem ? r : q;
        if (word) v = {{32{v[31]}}, v[31:0]};
        return v;
    endfunction

    task automatic check_result(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t ns: result %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("** Error at %0t ns: latency %0d cycles, expected %0d", $time, got, exp);
        end
    endtask

    // one request, optionally followed by a second strobe while busy
    task automatic run_op(input logic uns, input logic rem, input logic word,
            input logic [xlen-1:0] x, input logic [xlen-1:0] y, input bit intrude);
        @(posedge clk);
        #1;
        ena         = 1'b1;
        unsigned_op = uns;
        rem_op      = rem;
        word_op     = word;
        a1          = x;
        a2          = y;
        exp_q.push_back(ref_result(uns, rem, word, x, y));
        issue_q.push_back(cycle + 1);
        issued++;
        @(posedge clk);
        #1;
        ena = 1'b0;
        if (intrude) begin
            repeat (3) @(posedge clk);
            #1;
            // dropped by the DUT, no result expected
            ena    = 1'b1;
            a1     = take_bits(64);
            a2     = take_bits(64);
            rem_op = ~rem_op;
            @(posedge clk);
            #1;
            ena = 1'b0;
        end
        @(negedge clk);
        while (!valid) begin
            if (!busy) begin
                proto_errors++;
                $display("busy went low at %0t ns before the result arrived", $time);
            end
            @(negedge clk);
        end
        if (busy) begin
            proto_errors++;
            $display("busy still high at %0t ns while valid is high", $time);
        end
    endtask

    // compare process
    initial begin
        forever begin
            @(negedge clk);
            if (valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    proto_errors++;
                    $display("result at %0t ns without a pending request", $time);
                end else begin
                    check_result(res, exp_q.pop_front());
                    check_latency(cycle - issue_q.pop_front(), latency);
                end
                received++;
            end
        end
    end

    initial begin
        logic [xlen-1:0] x;
        logic [xlen-1:0] y;
        lfsr         = 32'h52b5_982c;
        value_errors = 0;
        proto_errors = 0;
        issued       = 0;
        received     = 0;
        ena          = 1'b0;
        unsigned_op  = 1'b0;
        rem_op       = 1'b0;
        word_op      = 1'b0;
        a1           = '0;
        a2           = '0;
        reset        = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // unsigned divu and remu
        for (int i = 0; i < n_random; i++) begin
            x = rand_operand();
            y = rand_operand();
            run_op(1'b1, 1'(take_bits(1)), 1'b0, x, y, 1'b0);
        end

        // signed div and rem, sign combinations in turn
        for (int i = 0; i < n_random; i++) begin
            x = rand_operand() & {1'b0, {(xlen-1){1'b1}}};
            y = rand_operand() & {1'b0, {(xlen-1){1'b1}}};
            if (i[0]) x = -x;
            if (i[1]) y = -y;
            run_op(1'b0, 1'(take_bits(1)), 1'b0, x, y, 1'b0);
        end

        // divide by zero in all eight forms, word divisors carry junk above bit 31
        for (int f = 0; f < 8; f++) begin
            x = take_bits(64);
            y = take_bits(64);
            y[31:0] = 32'h0;
            if (!f[2]) y = '0;
            run_op(f[0], f[1], f[2], x, y, 1'b0);
        end

        // most negative value over minus one
        for (int f = 0; f < 4; f++) begin
            if (f[1]) begin
                x = take_bits(64);
                y = take_bits(64);
                x[31:0] = 32'h8000_0000;
                y[31:0] = 32'hffff_ffff;
            end else begin
                x = {1'b1, {(xlen-1){1'b0}}};
                y = '1;
            end
            run_op(1'b0, f[0], f[1], x, y, 1'b0);
        end

        // word forms with garbage upper halves
        for (int i = 0; i < n_random; i++) begin
            x = take_bits(64);
            y = take_bits(64);
            x[31:0] = 32'(rand_operand());
            y[31:0] = 32'(rand_operand());
            if (i[0]) x[31:0] = -x[31:0];
            if (i[1]) y[31:0] = -y[31:0];
            run_op(1'(take_bits(1)), 1'(take_bits(1)), 1'b1, x, y, 1'b0);
        end

        // requests made while busy
        for (int i = 0; i < 4; i++) begin
            x = rand_operand();
            y = rand_operand() | 64'h1;
            run_op(1'(take_bits(1)), 1'(take_bits(1)), 1'b0, x, y, 1'b1);
        end

        repeat (4) @(posedge clk);
        if (received != issued) begin
            proto_errors++;
            $display("%0d requests issued but %0d results returned", issued, received);
        end
        $display("value errors %0d, protocol errors %0d, assertion failures %0d",
                 value_errors, proto_errors, dut_i.props_i.fail_count);
        if (value_errors + proto_errors + dut_i.props_i.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout after %0d cycles, the run did not finish", watchdog_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

/* test/int_divider_props.sv */
//****************************************
// protocol checks for the integer divider
// strobe, valid pulse and busy level
//****************************************

`timescale 1ns/10ps

module int_divider_props (
    input logic clk,
    input logic reset,
    input logic ena,
    input logic valid,
    input logic busy
);

    int   fail_count;
    logic accepted;

    initial fail_count = 0;

    assign accepted = ena & ~busy;

    // valid is a single-cycle pulse
    valid_pulse: assert property (@(posedge clk) disable iff (reset) valid |=> !valid)
        else begin
            $error("valid held for more than one cycle");
            fail_count++;
        end

    // valid rises on the 18th edge after the accepting edge and is sampled one edge later
    valid_latency: assert property (@(posedge clk) disable iff (reset)
        valid == $past(accepted, 19))
        else begin
            $error("valid does not follow an accepted request by 18 cycles");
            fail_count++;
        end

    busy_after_reset: assert property (@(posedge clk) reset |=> !busy)
        else begin
            $error("busy high after reset");
            fail_count++;
        end

    // busy falls in exactly the cycles where valid is high
    busy_fall: assert property (@(posedge clk) disable iff (reset) $fell(busy) == valid)
        else begin
            $error("busy does not fall together with valid");
            fail_count++;
        end

endmodule

bind int_divider int_divider_props props_i (
    .clk   (clk),
    .reset (reset),
    .ena   (ena),
    .valid (valid),
    .busy  (busy)
);

/* hdl/int_divider.sv */
//**************************************
// 64-bit integer divider
// div, divu, rem, remu and word forms
//**************************************

`timescale 1ns/10ps

module int_divider (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ena,
    input  logic                         unsigned_op,
    input  logic                         rem_op,
    input  logic                         word_op,
    input  logic [divider_pkg::xlen-1:0] a1,
    input  logic [divider_pkg::xlen-1:0] a2,
    output logic [divider_pkg::xlen-1:0] res,
    output logic                         valid,
    output logic                         busy
);

    import divider_pkg::*;

    logic            start;
    logic [xlen-1:0] abs_dividend;
    logic [xlen-1:0] abs_divisor;
    logic [xlen-1:0] orig_dividend;
    logic            neg_quot;
    logic            neg_rem;
    logic            div_zero;
    logic            overflow;
    logic            rem_sel;
    logic            word_sel;
    logic            iter_done;
    logic [xlen-1:0] quotient;
    logic [xlen-1:0] remainder;

    // valid also ends the operation in the request stage
    div_operand_prep prep_i (
        .clk           (clk),
        .reset         (reset),
        .ena           (ena),
        .unsigned_op   (unsigned_op),
        .rem_op        (rem_op),
        .word_op       (word_op),
        .a1            (a1),
        .a2            (a2),
        .done          (valid),
        .busy          (busy),
        .start         (start),
        .abs_dividend  (abs_dividend),
        .abs_divisor   (abs_divisor),
        .orig_dividend (orig_dividend),
        .neg_quot      (neg_quot),
        .neg_rem       (neg_rem),
        .div_zero      (div_zero),
        .overflow      (overflow),
        .rem_sel       (rem_sel),
        .word_sel      (word_sel)
    );

    div_iter_core iter_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .done         (iter_done),
        .quotient     (quotient),
        .remainder    (remainder)
    );

    div_result_fmt fmt_i (
        .clk           (clk),
        .reset         (reset),
        .done          (iter_done),
        .quotient      (quotient),
        .remainder     (remainder),
        .orig_dividend (orig_dividend),
        .neg_quot      (neg_quot),
        .neg_rem       (neg_rem),
        .div_zero      (div_zero),
        .overflow      (overflow),
        .rem_sel       (rem_sel),
        .word_sel      (word_sel),
        .res           (res),
        .valid         (valid)
    );

endmodule

/* hdl/div_result_fmt.sv */
//**************************************
// divider result stage
// signs, special cases and word extension
//**************************************

`timescale 1ns/10ps

module div_result_fmt (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         done,
    input  logic [divider_pkg::xlen-1:0] quotient,
    input  logic [divider_pkg::xlen-1:0] remainder,
    input  logic [divider_pkg::xlen-1:0] orig_dividend,
    input  logic                         neg_quot,
    input  logic                         neg_rem,
    input  logic                         div_zero,
    input  logic                         overflow,
    input  logic                         rem_sel,
    input  logic                         word_sel,
    output logic [divider_pkg::xlen-1:0] res,
    output logic                         valid
);

    import divider_pkg::*;

    logic [xlen-1:0] pick;
    logic            pick_neg;
    div_operand_u    fmt_u;
    logic [xlen-1:0] fmt_val;

    always_comb begin
        pick     = rem_sel ? remainder : quotient;
        pick_neg = rem_sel ? neg_rem : neg_quot;
        fmt_u.dword = pick_neg ? -pick : pick;
        // RISC-V values for x/0 and min/-1
        if (div_zero) begin
            fmt_u.dword = rem_sel ? orig_dividend : '1;
        end else if (overflow) begin
            fmt_u.dword = rem_sel ? '0 : orig_dividend;
        end
        // word results are sign extended from bit 31
        if (word_sel) begin
            fmt_val = {{(xlen/2){fmt_u.half.lo[xlen/2-1]}}, fmt_u.half.lo};
        end else begin
            fmt_val = fmt_u.dword;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            res <= fmt_val;
        end
    end

endmodule

/* hdl/div_iter_core.sv */
//**************************************
// divider iterator
// runs sixteen radix-16 steps on the
// residual, divisor and quotient
//**************************************

`timescale 1ns/10ps

module div_iter_core (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic [divider_pkg::xlen-1:0] abs_dividend,
    input  logic [divider_pkg::xlen-1:0] abs_divisor,
    output logic                         done,
    output logic [divider_pkg::xlen-1:0] quotient,
    output logic [divider_pkg::xlen-1:0] remainder
);

    import divider_pkg::*;

    logic [xlen-1:0]              resid_q;
    logic [divisor_w-1:0]         divisor_q;
    logic [xlen-1:0]              quot_q;
    logic [xlen-1:0]              stage_in;
    logic [divisor_w-1:0]         stage_dsr;
    logic [xlen-1:0]              stage_resid;
    logic [stage_bits-1:0]        stage_qbits;
    logic                         running;
    logic [$clog2(div_steps)-1:0] step_cnt;

    // the start cycle feeds the fresh operands straight into the first step
    assign stage_in  = start ? abs_dividend : resid_q;
    assign stage_dsr = start ? {abs_divisor, {(divisor_w - xlen){1'b0}}} : divisor_q;

    divstage64 stage_i (
        .divident (stage_in),
        .divisor  (stage_dsr),
        .resid    (stage_resid),
        .bits     (stage_qbits)
    );

    // step counter, done follows the last of div_steps steps
    always_ff @(posedge clk) begin
        if (reset) begin
            running  <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == ($clog2(div_steps))'(div_steps - 2)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // old quotient bits are shifted out completely over a full run
    always_ff @(posedge clk) begin
        if (start || running) begin
            resid_q   <= stage_resid;
            divisor_q <= stage_dsr >> stage_bits;
            quot_q    <= {quot_q[xlen-stage_bits-1:0], stage_qbits};
        end
    end

    assign quotient  = quot_q;
    assign remainder = resid_q;

endmodule

/* hdl/div_operand_prep.sv */
//**************************************
// divider request stage
// captures a request, forms absolute values
// and flags the special cases
//**************************************

`timescale 1ns/10ps

module div_operand_prep (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ena,
    input  logic                         unsigned_op,
    input  logic                         rem_op,
    input  logic                         word_op,
    input  logic [divider_pkg::xlen-1:0] a1,
    input  logic [divider_pkg::xlen-1:0] a2,
    input  logic                         done,
    output logic                         busy,
    output logic                         start,
    output logic [divider_pkg::xlen-1:0] abs_dividend,
    output logic [divider_pkg::xlen-1:0] abs_divisor,
    output logic [divider_pkg::xlen-1:0] orig_dividend,
    output logic                         neg_quot,
    output logic                         neg_rem,
    output logic                         div_zero,
    output logic                         overflow,
    output logic                         rem_sel,
    output logic                         word_sel
);

    import divider_pkg::*;

    logic            busy_q;
    logic            req_q;
    logic            accept;
    logic            uns_q;
    logic            rem_q;
    logic            word_q;
    div_operand_u    op1_q;
    div_operand_u    op2_q;
    logic [xlen-1:0] ext1;
    logic [xlen-1:0] ext2;
    logic            neg1;
    logic            neg2;
    logic            min_val;

    // busy drops in the valid cycle, a request there starts the next operation
    assign busy   = busy_q & ~done;
    assign accept = ena & ~busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
            start  <= 1'b0;
        end else begin
            req_q <= accept;
            start <= req_q;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // raw request, held until the next accepted strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            op1_q.dword <= a1;
            op2_q.dword <= a2;
            uns_q       <= unsigned_op;
            rem_q       <= rem_op;
            word_q      <= word_op;
        end
    end

    // word forms use the lower half only, extended by signedness
    always_comb begin
        if (word_q) begin
            ext1    = {{(xlen/2){op1_q.half.lo[xlen/2-1] & ~uns_q}}, op1_q.half.lo};
            ext2    = {{(xlen/2){op2_q.half.lo[xlen/2-1] & ~uns_q}}, op2_q.half.lo};
            min_val = (op1_q.half.lo == {1'b1, {(xlen/2-1){1'b0}}});
        end else begin
            ext1    = op1_q.dword;
            ext2    = op2_q.dword;
            min_val = (op1_q.dword == {1'b1, {(xlen-1){1'b0}}});
        end
        neg1 = ~uns_q & ext1[xlen-1];
        neg2 = ~uns_q & ext2[xlen-1];
    end

    // operands for the iterator and per-operation flags for the formatter
    always_ff @(posedge clk) begin
        if (req_q) begin
            abs_dividend  <= neg1 ? -ext1 : ext1;
            abs_divisor   <= neg2 ? -ext2 : ext2;
            orig_dividend <= ext1;
            neg_quot      <= neg1 ^ neg2;
            neg_rem       <= neg1;
            div_zero      <= ~|ext2;
            // most negative value over minus one
            overflow      <= ~uns_q & min_val & (&ext2);
            rem_sel       <= rem_q;
            word_sel      <= word_q;
        end
    end

endmodule

/* hdl/divstage64.sv */
//**************************************
// radix-16 divider step
// picks the largest multiple of the divisor
// that fits into the residual
//**************************************

`timescale 1ns/10ps

module divstage64 (
    input  logic [divider_pkg::xlen-1:0]       divident,
    input  logic [divider_pkg::divisor_w-1:0]  divisor,
    output logic [divider_pkg::xlen-1:0]       resid,
    output logic [divider_pkg::stage_bits-1:0] bits
);

    import divider_pkg::*;

    // multiples are four bits wider than a dword so that 15x is exact
    logic [xlen+stage_bits-1:0] mult [1:2**stage_bits-1];
    // residual after subtracting each multiple, top bit is the borrow
    logic [xlen:0]              diff [1:2**stage_bits-1];
    logic [2**stage_bits-1:1]   ovf;
    logic [2**stage_bits-1:1]   fits;
    logic                       hi_nz;

    // divisor bits above the dword make every multiple too large
    assign hi_nz = |divisor[divisor_w-1:xlen];

    // multiples from shifts and a single add or subtract each
    always_comb begin
        mult[1]  = {{stage_bits{1'b0}}, divisor[xlen-1:0]};
        mult[2]  = mult[1] << 1;
        mult[3]  = mult[2] + mult[1];
        mult[4]  = mult[1] << 2;
        mult[5]  = mult[4] + mult[1];
        mult[6]  = mult[3] << 1;
        mult[8]  = mult[1] << 3;
        // 7 is taken as 8 - 1
        mult[7]  = mult[8] - mult[1];
        mult[9]  = mult[8] + mult[1];
        mult[10] = mult[5] << 1;
        mult[11] = mult[8] + mult[3];
        mult[12] = mult[3] << 2;
        mult[13] = mult[12] + mult[1];
        mult[14] = mult[7] << 1;
        // 16x still fits in the wider word
        mult[15] = (mult[1] << 4) - mult[1];
    end

    // a multiple overflows when it needs bits above the dword
    always_comb begin
        for (int k = 1; k < 2**stage_bits; k++) begin
            ovf[k] = hi_nz | (|mult[k][xlen+stage_bits-1:xlen]);
        end
    end

    // trial subtraction of every multiple in parallel
    always_comb begin
        for (int k = 1; k < 2**stage_bits; k++) begin
            diff[k] = {1'b0, divident} - {1'b0, mult[k][xlen-1:0]};
            fits[k] = ~ovf[k] & ~diff[k][xlen];
        end
    end

    // fits is monotonic in k, so the last hit in ascending order is the largest
    always_comb begin
        bits  = '0;
        resid = divident;
        for (int k = 1; k < 2**stage_bits; k++) begin
            if (fits[k]) begin
                bits  = stage_bits'(k);
                resid = diff[k][xlen-1:0];
            end
        end
    end

endmodule

/* hdl/divider_pkg.sv */
//**************************************
// shared widths and the operand view of
// the 64-bit integer divider
//**************************************

package divider_pkg;

    // operand and result width
    localparam int xlen = 64;

    // quotient bits produced per radix-16 step
    localparam int stage_bits = 4;

    // steps needed to cover a full dword
    localparam int div_steps = xlen / stage_bits;

    // divisor register holds the operand shifted up by 60
    localparam int divisor_w = xlen + xlen - stage_bits;

    // upper and lower words of a dword
    typedef struct packed {
        logic [xlen/2-1:0] hi;
        logic [xlen/2-1:0] lo;
    } div_halves_t;

    // one operand word, seen whole or as two halves
    typedef union packed {
        logic [xlen-1:0] dword;
        div_halves_t     half;
    } div_operand_u;

endpackage
